/* sources.f */
common/icache_pkg.sv
common/icache_way_if.sv
icache_way/icache_way.sv
icache_ctrl/icache_ctrl.sv
hw/icache_top.sv
bench/tb_mem_model.sv
bench/tb_icache.sv

/* Bender.yml */
package:
  name: icache

sources:
  - common/icache_pkg.sv
  - common/icache_way_if.sv
  - icache_way/icache_way.sv
  - icache_ctrl/icache_ctrl.sv
  - hw/icache_top.sv
  - target: test
    files:
      - bench/tb_mem_model.sv
      - bench/tb_icache.sv

/* bench/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;
    import icache_pkg::*;

    localparam int LINE_WIDTH = 512;
    localparam int N_FETCH    = 36;               // directed 20 plus random 16
    localparam int TIMEOUT    = 40 * N_FETCH;

    logic clk, rstn, i_req_valid, i_req_uncached, o_req_ready;
    logic o_resp_valid, o_resp_exc, o_mem_rvalid, i_mem_rready;
    logic [31:0] i_req_addr, o_resp_pc, o_mem_raddr, addr, base;
    logic [63:0] o_resp_data;
    logic [7:0] o_mem_rlen;
    logic [LINE_WIDTH-1:0] i_mem_rdata;

    int seed;
    int r;
    int req_n = 0;
    int mem_exp = 0;
    int acc_cnt = 0;
    int rsp_cnt = 0;
    int mem_cnt = 0;
    int cycles = 0;

    // tags A, B, A, C, A, B in one set
    int seq_tag [6] = '{0, 1, 0, 2, 0, 1};

    // expectations per request, indexed in issue order
    logic [31:0] exp_pc [N_FETCH];
    logic [63:0] exp_data [N_FETCH];
    logic [31:0] exp_raddr [N_FETCH];
    logic [7:0] exp_rlen [N_FETCH];
    logic exp_exc [N_FETCH];
    logic exp_fast [N_FETCH];     // answered in the cycle after acceptance
    int exp_mem [N_FETCH];        // memory reads seen once it has answered

    // two ways per set, 64 sets, 20-bit tags
    logic [19:0] mtag [64][2];
    logic mval [64][2];
    logic mlru [64];              // way used last

    icache_top u_dut (.*);

    tb_mem_model #(.LINE_WIDTH(LINE_WIDTH), .SEED(32'hed97_c1ce)) u_mem (
        .clk(clk), .rstn(rstn), .i_rvalid(o_mem_rvalid), .i_raddr(o_mem_raddr),
        .i_rlen(o_mem_rlen), .o_rready(i_mem_rready), .o_rdata(i_mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic end_failed();
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("FAILED at %0t ns, %s expected %h, got %h", $time, name, exp, act);
        end_failed();
    endtask

    function automatic logic [63:0] pattern_pair(input logic [31:0] a);
        logic [31:0] a8;
        a8 = {a[31:3], 3'b000};
        return {(a8 + 32'd4) ^ 32'h5a5a_0000, a8 ^ 32'h5a5a_0000};
    endfunction

    // returns the hit and updates tags and LRU like the cache should
    function automatic logic lookup_model(input logic [31:0] a);
        logic [5:0] set;
        logic victim;
        set = a[11:6];
        for (int w = 0; w < 2; w++) begin
            if (mval[set][w] && mtag[set][w] == a[31:12]) begin
                mlru[set] = w[0];
                return 1'b1;
            end
        end
        victim = !mlru[set];
        mval[set][victim] = 1'b1;
        mtag[set][victim] = a[31:12];
        mlru[set] = victim;
        return 1'b0;
    endfunction

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic issue(input logic [31:0] a, input logic unc);
        int n;
        n = req_n;
        exp_pc[n] = a;
        exp_exc[n] = (a[1:0] != 2'b00);
        exp_raddr[n] = unc ? {a[31:3], 3'b000} : {a[31:6], 6'b000000};
        exp_rlen[n] = unc ? 8'd1 : 8'd15;
        exp_data[n] = exp_exc[n] ? {INST_NOP, INST_NOP} : pattern_pair(a);
        exp_fast[n] = exp_exc[n] || (!unc && lookup_model(a));
        mem_exp = mem_exp + (exp_fast[n] ? 0 : 1);
        exp_mem[n] = mem_exp;
        req_n = n + 1;
        i_req_valid = 1'b1;
        i_req_addr = a;
        i_req_uncached = unc;
        while (acc_cnt != req_n) @(negedge clk);
    endtask

    task automatic drain();
        i_req_valid = 1'b0;
        while (rsp_cnt != req_n) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (i_req_valid && o_req_ready) acc_cnt <= acc_cnt + 1;
        if (o_resp_valid) rsp_cnt <= rsp_cnt + 1;
        if (o_mem_rvalid && i_mem_rready) mem_cnt <= mem_cnt + 1;
        if (cycles > TIMEOUT) begin
            $display("run did not finish within %0d cycles", TIMEOUT);
            end_failed();
        end
    end

    a_reset_state : assert property (@(posedge clk)
        $rose(rstn) |-> (o_req_ready && !o_resp_valid && !o_mem_rvalid))
        else begin
            $display("outputs are not in their reset state after reset");
            end_failed();
        end
    a_resp_pc : assert property (@(posedge clk) disable iff (!rstn)
        o_resp_valid |-> o_resp_pc == exp_pc[rsp_cnt])
        else mismatch("o_resp_pc", exp_pc[$sampled(rsp_cnt)], $sampled(o_resp_pc));
    a_resp_data : assert property (@(posedge clk) disable iff (!rstn)
        o_resp_valid |-> o_resp_data == exp_data[rsp_cnt])
        else mismatch("o_resp_data", exp_data[$sampled(rsp_cnt)], $sampled(o_resp_data));
    a_resp_exc : assert property (@(posedge clk) disable iff (!rstn)
        o_resp_valid |-> o_resp_exc == exp_exc[rsp_cnt])
        else mismatch("o_resp_exc", exp_exc[$sampled(rsp_cnt)], $sampled(o_resp_exc));
    a_mem_count : assert property (@(posedge clk) disable iff (!rstn)
        o_resp_valid |-> mem_cnt == exp_mem[rsp_cnt])
        else mismatch("memory reads", exp_mem[$sampled(rsp_cnt)], $sampled(mem_cnt));
    a_mem_addr : assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rvalid |-> o_mem_raddr == exp_raddr[rsp_cnt])
        else mismatch("o_mem_raddr", exp_raddr[$sampled(rsp_cnt)], $sampled(o_mem_raddr));
    a_mem_len : assert property (@(posedge clk) disable iff (!rstn)
        o_mem_rvalid |-> o_mem_rlen == exp_rlen[rsp_cnt])
        else mismatch("o_mem_rlen", exp_rlen[$sampled(rsp_cnt)], $sampled(o_mem_rlen));
    a_fast_resp : assert property (@(posedge clk) disable iff (!rstn)
        (i_req_valid && o_req_ready && exp_fast[acc_cnt]) |=> o_resp_valid)
        else mismatch("o_resp_valid", 64'd1, 64'd0);
    a_slow_resp : assert property (@(posedge clk) disable iff (!rstn)
        (i_req_valid && o_req_ready && !exp_fast[acc_cnt]) |=> !o_resp_valid)
        else mismatch("o_resp_valid", 64'd0, 64'd1);
    // a lookup answer frees the cache for the next fetch in the same cycle
    a_hit_ready : assert property (@(posedge clk) disable iff (!rstn)
        (o_resp_valid && exp_fast[rsp_cnt]) |-> o_req_ready)
        else mismatch("o_req_ready", 64'd1, $sampled(o_req_ready));

    initial begin
        seed = 32'hed97_c1ce;
        rstn = 1'b0;
        i_req_valid = 1'b0;
        i_req_addr = '0;
        i_req_uncached = 1'b0;
        for (int s = 0; s < 64; s++) begin
            mval[s][0] = 1'b0;
            mval[s][1] = 1'b0;
            mlru[s] = 1'b0;
        end
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        // miss then hit on the same fetch
        r = $random(seed);
        addr = {4'h1, r[15:0], 6'd5, 4'd6, 2'b00};
        issue(addr, 1'b0);
        drain();
        issue(addr, 1'b0);
        drain();

        // A, B, A, C into one set, then A hits and B misses
        base = {4'h2, r[23:8], 6'd9, 6'h10};
        foreach (seq_tag[i]) begin
            issue(base + (32'(seq_tag[i]) << 12), 1'b0);
        end
        drain();

        // uncached goes to memory both times
        addr = {4'h3, r[15:0], 6'd12, 6'h2c};
        issue(addr, 1'b1);
        issue(addr, 1'b1);
        drain();

        issue(32'h0000_4a02, 1'b0);   // misaligned
        drain();

        // fill one line, then eight hits with valid held
        addr = {4'h5, r[15:0], 6'd20, 6'h00};
        issue(addr, 1'b0);
        drain();
        for (int k = 0; k < 8; k++) begin
            issue(addr + 32'(8 * k), 1'b0);
        end
        drain();

        // random mix over four tags and two sets
        for (int k = 0; k < 16; k++) begin
            r = $random(seed);
            issue({18'h1_0000, r[1:0], 5'd0, r[2], r[6:3], 2'b00}, r[10:8] == 3'd0);
        end
        drain();

        repeat (2) @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* bench/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int LINE_WIDTH = 512,
    parameter int SEED       = 0
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_rvalid,
    input  logic [31:0]           i_raddr,
    input  logic [7:0]            i_rlen,
    output logic                  o_rready,
    output logic [LINE_WIDTH-1:0] o_rdata
);
    localparam int WORDS = LINE_WIDTH / 32;

    int   seed     = SEED;
    int   wait_cnt = 0;
    logic busy     = 1'b0;   // a request is being delayed

    // word at byte address a is a ^ 32'h5a5a_0000, beats past rlen read as zero
    function automatic logic [LINE_WIDTH-1:0] read_burst(
        input logic [31:0] base,
        input logic [7:0]  len
    );
        logic [LINE_WIDTH-1:0] line;
        logic [31:0]           a;
        line = '0;
        for (int i = 0; i < WORDS; i++) begin
            a = base + 32'(4 * i);
            if (i <= int'(len)) begin
                line[i*32 +: 32] = a ^ 32'h5a5a_0000;
            end
        end
        return line;
    endfunction

    initial begin
        o_rready = 1'b0;
        o_rdata  = '0;
    end

    // answer after 1 to 4 cycles, one ready beat carries the whole burst
    always @(negedge clk) begin
        o_rready <= 1'b0;
        if (!rstn) begin
            busy = 1'b0;
        end else if (i_rvalid && !o_rready) begin
            if (!busy) begin
                busy     = 1'b1;
                wait_cnt = 1 + ($unsigned($random(seed)) % 4);
            end
            wait_cnt = wait_cnt - 1;
            if (wait_cnt == 0) begin
                o_rready <= 1'b1;
                o_rdata  <= read_burst(i_raddr, i_rlen);
                busy     = 1'b0;
            end
        end
    end

endmodule

/* hw/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
    parameter int  INDEX_WIDTH       = icache_pkg::DEF_INDEX_WIDTH,
    parameter int  WORD_OFFSET_WIDTH = icache_pkg::DEF_WORD_OFFSET_WIDTH,
    localparam int LINE_WIDTH        = 32 << WORD_OFFSET_WIDTH
) (
    input  logic                  clk,
    input  logic                  rstn,

    // fetch request
    input  logic                  i_req_valid,
    input  icache_pkg::addr_t     i_req_addr,
    input  logic                  i_req_uncached,
    output logic                  o_req_ready,

    // fetch response, single cycle pulse
    output logic                  o_resp_valid,
    output icache_pkg::fetch_t    o_resp_data,
    output icache_pkg::addr_t     o_resp_pc,
    output logic                  o_resp_exc,

    // memory read channel
    output logic                  o_mem_rvalid,
    output icache_pkg::addr_t     o_mem_raddr,
    output logic [7:0]            o_mem_rlen,
    input  logic                  i_mem_rready,
    input  logic [LINE_WIDTH-1:0] i_mem_rdata
);

    icache_way_if #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) way0_if ();

    icache_way_if #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) way1_if ();

    icache_way #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) u_way0 (
        .clk  (clk),
        .rstn (rstn),
        .bus  (way0_if.way)
    );

    icache_way #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) u_way1 (
        .clk  (clk),
        .rstn (rstn),
        .bus  (way1_if.way)
    );

    icache_ctrl #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) u_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .i_req_valid    (i_req_valid),
        .i_req_addr     (i_req_addr),
        .i_req_uncached (i_req_uncached),
        .o_req_ready    (o_req_ready),
        .o_resp_valid   (o_resp_valid),
        .o_resp_data    (o_resp_data),
        .o_resp_pc      (o_resp_pc),
        .o_resp_exc     (o_resp_exc),
        .o_mem_rvalid   (o_mem_rvalid),
        .o_mem_raddr    (o_mem_raddr),
        .o_mem_rlen     (o_mem_rlen),
        .i_mem_rready   (i_mem_rready),
        .i_mem_rdata    (i_mem_rdata),
        .way0           (way0_if.ctrl),
        .way1           (way1_if.ctrl)
    );

endmodule

/* icache_ctrl/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int  INDEX_WIDTH       = icache_pkg::DEF_INDEX_WIDTH,
    parameter int  WORD_OFFSET_WIDTH = icache_pkg::DEF_WORD_OFFSET_WIDTH,
    localparam int LINE_WIDTH        = 32 << WORD_OFFSET_WIDTH
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_req_valid,
    input  icache_pkg::addr_t     i_req_addr,
    input  logic                  i_req_uncached,
    output logic                  o_req_ready,
    output logic                  o_resp_valid,
    output icache_pkg::fetch_t    o_resp_data,
    output icache_pkg::addr_t     o_resp_pc,
    output logic                  o_resp_exc,
    output logic                  o_mem_rvalid,
    output icache_pkg::addr_t     o_mem_raddr,
    output logic [7:0]            o_mem_rlen,
    input  logic                  i_mem_rready,
    input  logic [LINE_WIDTH-1:0] i_mem_rdata,
    icache_way_if.ctrl            way0,
    icache_way_if.ctrl            way1
);
    import icache_pkg::*;

    localparam int BYTE_OFF_WIDTH  = WORD_OFFSET_WIDTH + 2;
    localparam int TAG_WIDTH       = 32 - INDEX_WIDTH - BYTE_OFF_WIDTH;
    localparam int SET_NUM         = 1 << INDEX_WIDTH;
    localparam int SLOT_WIDTH      = WORD_OFFSET_WIDTH - 1;   // 64-bit slots per line
    localparam logic [7:0] LINE_RLEN = 8'((1 << WORD_OFFSET_WIDTH) - 1);

    state_e                 state_q;
    state_e                 state_d;

    addr_t                  req_addr_q;   // request buffer
    logic                   req_unc_q;
    logic [LINE_WIDTH-1:0]  ret_buf;      // line from memory
    logic [SET_NUM-1:0]     lru_q;        // way used last, per set
    logic                   victim_q;

    logic [INDEX_WIDTH-1:0] req_idx;
    logic [INDEX_WIDTH-1:0] new_idx;
    logic [INDEX_WIDTH-1:0] rd_index;
    logic [TAG_WIDTH-1:0]   req_tag;
    logic [SLOT_WIDTH-1:0]  req_slot;
    logic                   misaligned;
    logic                   lookup_done;
    logic                   refill_wr;
    logic                   set_clash;
    logic                   accept;
    logic                   victim_way;
    logic [LINE_WIDTH-1:0]  hit_line;

    function automatic fetch_t pick_slot(
        input logic [LINE_WIDTH-1:0] line,
        input logic [SLOT_WIDTH-1:0] slot
    );
        return line[slot*64 +: 64];
    endfunction

    assign req_idx  = req_addr_q[BYTE_OFF_WIDTH +: INDEX_WIDTH];
    assign new_idx  = i_req_addr[BYTE_OFF_WIDTH +: INDEX_WIDTH];
    assign req_tag  = req_addr_q[31 -: TAG_WIDTH];
    assign req_slot = req_addr_q[3 +: SLOT_WIDTH];

    assign misaligned = |req_addr_q[1:0];
    // a lookup finishes on its own for an exception or a cached hit
    assign lookup_done = (state_q == LOOKUP) &&
                         (misaligned || ((way0.hit || way1.hit) && !req_unc_q));
    assign refill_wr   = (state_q == REFILL) && !req_unc_q;
    assign set_clash   = refill_wr && (new_idx == req_idx);

    // hold off a new fetch to the set being filled, it would read stale data
    assign o_req_ready = (state_q == IDLE) || lookup_done ||
                         ((state_q == REFILL) && !set_clash);
    assign accept      = i_req_valid && o_req_ready;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!lookup_done) begin
                    state_d = MISS;   // miss or uncached
                end else if (!accept) begin
                    state_d = IDLE;
                end
            end
            MISS: begin
                if (i_mem_rready) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                state_d = accept ? LOOKUP : IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr_q <= i_req_addr;
            req_unc_q  <= i_req_uncached;
        end
        if ((state_q == MISS) && i_mem_rready) begin
            ret_buf <= i_mem_rdata;   // whole line in one beat
        end
        if ((state_q == LOOKUP) && !lookup_done) begin
            victim_q <= victim_way;
        end
    end

    // empty way first, which agrees with LRU once the set is full
    assign victim_way = (way0.valid ^ way1.valid) ? way0.valid : ~lru_q[req_idx];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (lookup_done && !misaligned) begin
            lru_q[req_idx] <= way1.hit;
        end else if (refill_wr) begin
            lru_q[req_idx] <= victim_q;
        end
    end

    assign hit_line = way1.hit ? way1.line : way0.line;

    always_comb begin
        if (state_q == REFILL) begin
            o_resp_data = req_unc_q ? ret_buf[63:0] : pick_slot(ret_buf, req_slot);
        end else if (misaligned) begin
            o_resp_data = {INST_NOP, INST_NOP};
        end else begin
            o_resp_data = pick_slot(hit_line, req_slot);
        end
    end

    assign o_resp_valid = lookup_done || (state_q == REFILL);
    assign o_resp_pc    = req_addr_q;
    assign o_resp_exc   = (state_q == LOOKUP) && misaligned;

    assign o_mem_rvalid = (state_q == MISS);
    assign o_mem_raddr  = req_unc_q ? {req_addr_q[31:3], 3'b000}
                                    : {req_addr_q[31:BYTE_OFF_WIDTH], {BYTE_OFF_WIDTH{1'b0}}};
    assign o_mem_rlen   = req_unc_q ? MEM_LEN_UNCACHED : LINE_RLEN;

    // read port follows the incoming address, moved aside on a clash
    assign rd_index = set_clash ? req_idx + 1'b1 : new_idx;

    assign way0.rd_index   = rd_index;
    assign way0.lookup_tag = req_tag;
    assign way0.wr_en      = refill_wr && !victim_q;
    assign way0.wr_index   = req_idx;
    assign way0.wr_tag     = req_tag;
    assign way0.wr_line    = ret_buf;

    assign way1.rd_index   = rd_index;
    assign way1.lookup_tag = req_tag;
    assign way1.wr_en      = refill_wr && victim_q;
    assign way1.wr_index   = req_idx;
    assign way1.wr_tag     = req_tag;
    assign way1.wr_line    = ret_buf;

    // fills happen only on a miss, so a tag never sits in both ways
    a_single_hit : assert property (
        @(posedge clk) disable iff (!rstn)
        (state_q == LOOKUP) |-> !(way0.hit && way1.hit)
    ) else $error("both ways hit for pc %h", req_addr_q);

    a_mem_req_hold : assert property (
        @(posedge clk) disable iff (!rstn)
        (o_mem_rvalid && !i_mem_rready) |=> (o_mem_rvalid && $stable(o_mem_raddr))
    ) else $error("memory request dropped or changed before ready");

endmodule

/* icache_way/icache_way.sv */
`timescale 1ns/1ps

module icache_way #(
    parameter int INDEX_WIDTH       = icache_pkg::DEF_INDEX_WIDTH,
    parameter int WORD_OFFSET_WIDTH = icache_pkg::DEF_WORD_OFFSET_WIDTH
) (
    input  logic      clk,
    input  logic      rstn,
    icache_way_if.way bus
);
    localparam int TAG_WIDTH  = 32 - INDEX_WIDTH - WORD_OFFSET_WIDTH - 2;
    localparam int LINE_WIDTH = 32 << WORD_OFFSET_WIDTH;
    localparam int SET_NUM    = 1 << INDEX_WIDTH;

    // one valid flop per set, tags and lines in plain arrays
    logic [SET_NUM-1:0]    valid_q;
    logic [TAG_WIDTH-1:0]  tag_mem  [SET_NUM];
    logic [LINE_WIDTH-1:0] line_mem [SET_NUM];

    // registered read port
    logic                  rd_valid_q;
    logic [TAG_WIDTH-1:0]  rd_tag_q;
    logic [LINE_WIDTH-1:0] rd_line_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= valid_q[bus.rd_index];
            if (bus.wr_en) begin
                valid_q[bus.wr_index] <= 1'b1;   // lines are only ever filled
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.wr_en) begin
            tag_mem[bus.wr_index]  <= bus.wr_tag;
            line_mem[bus.wr_index] <= bus.wr_line;
        end
        rd_tag_q  <= tag_mem[bus.rd_index];
        rd_line_q <= line_mem[bus.rd_index];
    end

    // compare against the tag of the request now in lookup
    assign bus.valid = rd_valid_q;
    assign bus.hit   = rd_valid_q && (rd_tag_q == bus.lookup_tag);
    assign bus.line  = rd_line_q;

    // controller must steer the read port off a set it is refilling,
    // otherwise the next lookup would see the old line
    a_no_rw_same_set : assert property (
        @(posedge clk) disable iff (!rstn)
        bus.wr_en |-> (bus.rd_index != bus.wr_index)
    ) else $error("way read and write hit set %0d together", bus.wr_index);

endmodule

/* common/icache_way_if.sv */
`timescale 1ns/1ps

interface icache_way_if #(
    parameter int INDEX_WIDTH       = icache_pkg::DEF_INDEX_WIDTH,
    parameter int WORD_OFFSET_WIDTH = icache_pkg::DEF_WORD_OFFSET_WIDTH
);
    localparam int TAG_WIDTH  = 32 - INDEX_WIDTH - WORD_OFFSET_WIDTH - 2;
    localparam int LINE_WIDTH = 32 << WORD_OFFSET_WIDTH;

    // read side, result shows up one cycle later
    logic [INDEX_WIDTH-1:0] rd_index;
    logic [TAG_WIDTH-1:0]   lookup_tag;

    // refill write
    logic                   wr_en;
    logic [INDEX_WIDTH-1:0] wr_index;
    logic [TAG_WIDTH-1:0]   wr_tag;
    logic [LINE_WIDTH-1:0]  wr_line;

    // way outputs
    logic                   valid;
    logic                   hit;
    logic [LINE_WIDTH-1:0]  line;

    modport ctrl (
        output rd_index, lookup_tag, wr_en, wr_index, wr_tag, wr_line,
        input  valid, hit, line
    );

    modport way (
        input  rd_index, lookup_tag, wr_en, wr_index, wr_tag, wr_line,
        output valid, hit, line
    );

endinterface

/* common/icache_pkg.sv */
package icache_pkg;

    // address and data words seen by the fetch unit and memory
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // two instructions per fetch
    typedef logic [63:0] fetch_t;

    // andi r0, r0, 0
    localparam inst_t INST_NOP = 32'h0340_0000;

    // default geometry
    // 64 sets, 16 words (512 bits) per line
    localparam int DEF_INDEX_WIDTH       = 6;
    localparam int DEF_WORD_OFFSET_WIDTH = 4;

    // burst length codes are beats minus one
    localparam logic [7:0] MEM_LEN_UNCACHED = 8'd1;   // 8 bytes

    // controller states
    typedef enum logic [1:0] {
        IDLE   = 2'b00,   // waiting for a fetch
        LOOKUP = 2'b01,   // tag compare on the registered way outputs
        MISS   = 2'b10,   // memory read outstanding
        REFILL = 2'b11    // line back, respond and fill the victim
    } state_e;

endpackage
